//--- rtl/idiv_consts.svh
// ==========================================================
// sizing macros for the iterative divider
//   operand width and iteration counter width
// ==========================================================

`ifndef IDIV_CONSTS_SVH
`define IDIV_CONSTS_SVH

// operand width in bits, any width of 2 or more works
`define IDIV_WIDTH 32

// iteration counter width, must hold the value IDIV_WIDTH itself
`define IDIV_CNT_W ($clog2(`IDIV_WIDTH + 1))

`endif

//--- rtl/idiv_pkg.sv
// ==========================================================
// shared types of the iterative divider
//   request and result words, control word, status word
// ==========================================================

`include "idiv_consts.svh"

`default_nettype none

package idiv_pkg;

    // one division request
    typedef struct packed {
        logic [`IDIV_WIDTH-1:0] dividend;
        logic [`IDIV_WIDTH-1:0] divisor;
        logic                   signed_div;
    } idiv_req_t;

    // one division result
    typedef struct packed {
        logic [`IDIV_WIDTH-1:0] quotient;
        logic [`IDIV_WIDTH-1:0] remainder;
    } idiv_res_t;

    // per-cycle control word, controller to datapath
    typedef struct packed {
        logic       opa_sel;
        logic       opa_ld;
        logic       opa_inv;
        logic       opa_clr_n;
        logic [2:0] opb_sel;
        logic       opb_ld;
        logic       opb_inv;
        logic       opb_clr_n;
        logic [2:0] opc_sel;
        logic       opc_ld;
        logic       latch_signed;
        logic       latch_msb_divisor;
        logic       latch_msb_dividend;
        logic       adder_cin;
    } idiv_ctrl_t;

    // datapath conditions, datapath to controller
    typedef struct packed {
        logic zero_divisor;
        logic signed_div_r;
        logic adder_neg;
        logic opa_neg;
        logic opc_neg;
    } idiv_status_t;

endpackage

`default_nettype wire

//--- rtl/idiv_controller.sv
// ==========================================================
// sequencing FSM of the iterative divider
//   load, operand negate, non-restoring iterations,
//   remainder repair, sign correction and result hand-off
// ==========================================================

`include "idiv_consts.svh"

`default_nettype none

module idiv_controller import idiv_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,

    input  logic         v_i,
    output logic         ready_o,

    input  idiv_status_t status_i,
    output idiv_ctrl_t   ctrl_o,

    output logic         v_o,
    input  logic         yumi_i
);

    localparam int W     = `IDIV_WIDTH;
    localparam int CNT_W = `IDIV_CNT_W;
    localparam logic [CNT_W-1:0] CALC_LAST = CNT_W'(W);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_START,
        ST_NEG0,
        ST_NEG1,
        ST_SHIFT,
        ST_CALC,
        ST_REPAIR,
        ST_REMAIN,
        ST_QUOT,
        ST_DONE
    } state_e;

    state_e           state_r;
    state_e           state_n;
    logic [CNT_W-1:0] calc_cnt_r;
    logic             calc_done;
    logic             add_neg_r;
    logic             q_neg_r;
    logic             r_neg_r;
    logic             neg_ld;

    // ==========================================================
    // state, iteration counter and sign flags
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= ST_IDLE;
        end else begin
            state_r <= state_n;
        end
    end

    // W+1 calc cycles, counter wraps back to zero on the last one
    assign calc_done = (calc_cnt_r == CALC_LAST);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            calc_cnt_r <= '0;
        end else if (state_r == ST_CALC) begin
            calc_cnt_r <= calc_done ? '0 : calc_cnt_r + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            add_neg_r <= 1'b0;
            q_neg_r   <= 1'b0;
            r_neg_r   <= 1'b0;
        end else begin
            // sign of the previous adder result steers add or subtract
            add_neg_r <= status_i.adder_neg;
            if (neg_ld) begin
                // quotient negative when operand signs differ
                q_neg_r <= (status_i.opa_neg ^ status_i.opc_neg) & status_i.signed_div_r;
                // remainder follows the dividend sign
                r_neg_r <= status_i.opc_neg & status_i.signed_div_r;
            end
        end
    end

    // ==========================================================
    // control word per state
    // ==========================================================

    always_comb begin
        // defaults describe one calc iteration
        ctrl_o.opa_sel            = 1'b0;
        ctrl_o.opa_ld             = 1'b0;
        ctrl_o.opa_inv            = ~add_neg_r;
        ctrl_o.opa_clr_n          = 1'b1;
        ctrl_o.opb_sel            = 3'b001;
        ctrl_o.opb_ld             = 1'b1;
        ctrl_o.opb_inv            = 1'b0;
        ctrl_o.opb_clr_n          = 1'b1;
        ctrl_o.opc_sel            = 3'b001;
        ctrl_o.opc_ld             = 1'b1;
        ctrl_o.latch_signed       = 1'b0;
        ctrl_o.latch_msb_divisor  = 1'b0;
        ctrl_o.latch_msb_dividend = 1'b0;
        ctrl_o.adder_cin          = ~add_neg_r;
        neg_ld                    = 1'b0;
        state_n                   = state_r;

        case (state_r)
            ST_IDLE: begin
                // operands enter A and C only on an accepted request
                ctrl_o.opa_sel      = 1'b1;
                ctrl_o.opa_ld       = v_i;
                ctrl_o.opb_ld       = 1'b0;
                ctrl_o.opc_sel      = 3'b100;
                ctrl_o.opc_ld       = v_i;
                ctrl_o.latch_signed = v_i;
                if (v_i) begin
                    state_n = ST_START;
                end
            end
            ST_START: begin
                ctrl_o.opb_ld             = 1'b0;
                ctrl_o.opc_ld             = 1'b0;
                ctrl_o.latch_msb_divisor  = 1'b1;
                ctrl_o.latch_msb_dividend = 1'b1;
                state_n                   = ST_NEG0;
            end
            ST_NEG0: begin
                // B takes the dividend, A becomes |divisor|
                ctrl_o.opa_inv   = 1'b1;
                ctrl_o.opa_ld    = status_i.opa_neg & status_i.signed_div_r;
                ctrl_o.opb_clr_n = 1'b0;
                ctrl_o.opb_sel   = 3'b100;
                ctrl_o.opc_ld    = 1'b0;
                ctrl_o.adder_cin = 1'b1;
                neg_ld           = 1'b1;
                state_n          = ST_NEG1;
            end
            ST_NEG1: begin
                // C becomes |dividend| through -B
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_inv   = 1'b1;
                ctrl_o.opb_ld    = 1'b0;
                ctrl_o.opc_sel   = 3'b010;
                ctrl_o.opc_ld    = status_i.opc_neg & status_i.signed_div_r;
                ctrl_o.adder_cin = 1'b1;
                state_n          = ST_SHIFT;
            end
            ST_SHIFT: begin
                // zero partial remainder, first shift of C
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_clr_n = 1'b0;
                ctrl_o.adder_cin = 1'b0;
                state_n          = ST_CALC;
            end
            ST_CALC: begin
                // last iteration keeps B unshifted
                ctrl_o.opb_sel = calc_done ? 3'b010 : 3'b001;
                state_n        = calc_done ? ST_REPAIR : ST_CALC;
            end
            ST_REPAIR: begin
                // negative final remainder gets the divisor added back
                ctrl_o.opa_inv   = 1'b0;
                ctrl_o.opb_sel   = 3'b010;
                ctrl_o.opb_ld    = add_neg_r;
                ctrl_o.opc_ld    = 1'b0;
                ctrl_o.adder_cin = 1'b0;
                state_n          = ST_REMAIN;
            end
            ST_REMAIN: begin
                // signed remainder into A, quotient copied to B
                ctrl_o.opa_ld    = 1'b1;
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_sel   = 3'b100;
                ctrl_o.opb_inv   = r_neg_r;
                ctrl_o.opc_ld    = 1'b0;
                ctrl_o.adder_cin = r_neg_r;
                state_n          = status_i.zero_divisor ? ST_DONE : ST_QUOT;
            end
            ST_QUOT: begin
                ctrl_o.opa_clr_n = 1'b0;
                ctrl_o.opb_inv   = 1'b1;
                ctrl_o.opb_ld    = 1'b0;
                ctrl_o.opc_sel   = 3'b010;
                ctrl_o.opc_ld    = q_neg_r;
                ctrl_o.adder_cin = 1'b1;
                state_n          = ST_DONE;
            end
            ST_DONE: begin
                // result held until the consumer takes it
                ctrl_o.opb_ld = 1'b0;
                ctrl_o.opc_ld = 1'b0;
                if (yumi_i) begin
                    state_n = ST_IDLE;
                end
            end
            default: begin
                ctrl_o.opb_ld = 1'b0;
                ctrl_o.opc_ld = 1'b0;
                state_n       = ST_IDLE;
            end
        endcase
    end

    assign ready_o = (state_r == ST_IDLE);
    assign v_o     = (state_r == ST_DONE);

    // ==========================================================
    // checks
    // ==========================================================

    a_ready_valid_excl: assert property (@(posedge clk_i) disable iff (reset_i)
        !(ready_o && v_o))
        else $error("ready_o and v_o high together");

    a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (reset_i)
        yumi_i |-> v_o)
        else $error("yumi_i raised without v_o");

    a_cnt_range: assert property (@(posedge clk_i) disable iff (reset_i)
        calc_cnt_r <= CALC_LAST)
        else $error("iteration counter past operand width");

endmodule

`default_nettype wire

//--- rtl/idiv_datapath.sv
// ==========================================================
// operand datapath of the iterative divider
//   registers A, B and C with their source muxes,
//   inverting adder, sign latches and status
// ==========================================================

`include "idiv_consts.svh"

`default_nettype none

module idiv_datapath import idiv_pkg::*; (
    input  logic         clk_i,
    input  logic         reset_i,

    input  idiv_req_t    req_i,
    input  idiv_ctrl_t   ctrl_i,

    output idiv_status_t status_o,
    output idiv_res_t    res_o
);

    localparam int W = `IDIV_WIDTH;

    // all registers carry one extra sign bit
    logic [W:0] opa_r;
    logic [W:0] opb_r;
    logic [W:0] opc_r;
    logic [W:0] opa_mux;
    logic [W:0] opb_mux;
    logic [W:0] opc_mux;
    logic [W:0] opa_in;
    logic [W:0] opb_in;
    logic [W:0] add_out;
    logic       divisor_ext;
    logic       dividend_ext;
    logic       signed_div_r;
    logic       msb_divisor_r;
    logic       msb_dividend_r;

    // ==========================================================
    // source selection
    // ==========================================================

    // sign extension of the incoming operands, zero when unsigned
    assign divisor_ext  = req_i.signed_div & req_i.divisor[W-1];
    assign dividend_ext = req_i.signed_div & req_i.dividend[W-1];

    assign opa_mux = ctrl_i.opa_sel ? {divisor_ext, req_i.divisor} : add_out;

    // B: shifted remainder with next dividend bit, adder result, or C
    assign opb_mux = ({(W + 1){ctrl_i.opb_sel[0]}} & {add_out[W-1:0], opc_r[W]})
                   | ({(W + 1){ctrl_i.opb_sel[1]}} & add_out)
                   | ({(W + 1){ctrl_i.opb_sel[2]}} & opc_r);

    // C: shift in the new quotient bit, adder result, or the dividend
    assign opc_mux = ({(W + 1){ctrl_i.opc_sel[0]}} & {opc_r[W-1:0], ~add_out[W]})
                   | ({(W + 1){ctrl_i.opc_sel[1]}} & add_out)
                   | ({(W + 1){ctrl_i.opc_sel[2]}} & {dividend_ext, req_i.dividend});

    // ==========================================================
    // operand registers
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (ctrl_i.opa_ld) begin
            opa_r <= opa_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.opb_ld) begin
            opb_r <= opb_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl_i.opc_ld) begin
            opc_r <= opc_mux;
        end
    end

    // ==========================================================
    // inverting adder
    // ==========================================================

    // each operand may be inverted, then forced to zero
    assign opa_in = {(W + 1){ctrl_i.opa_clr_n}} & (opa_r ^ {(W + 1){ctrl_i.opa_inv}});
    assign opb_in = {(W + 1){ctrl_i.opb_clr_n}} & (opb_r ^ {(W + 1){ctrl_i.opb_inv}});

    // invert plus carry-in gives subtraction or negation
    assign add_out = opa_in + opb_in + {{W{1'b0}}, ctrl_i.adder_cin};

    // ==========================================================
    // sign latches
    // ==========================================================

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            signed_div_r   <= 1'b0;
            msb_divisor_r  <= 1'b0;
            msb_dividend_r <= 1'b0;
        end else begin
            if (ctrl_i.latch_signed) begin
                signed_div_r <= req_i.signed_div;
            end
            // operand signs as loaded, before any negation
            if (ctrl_i.latch_msb_divisor) begin
                msb_divisor_r <= opa_r[W];
            end
            if (ctrl_i.latch_msb_dividend) begin
                msb_dividend_r <= opc_r[W];
            end
        end
    end

    // ==========================================================
    // status and result
    // ==========================================================

    assign status_o.zero_divisor = ~|opa_r;
    assign status_o.signed_div_r = signed_div_r;
    assign status_o.adder_neg    = add_out[W];
    assign status_o.opa_neg      = msb_divisor_r;
    assign status_o.opc_neg      = msb_dividend_r;

    // A ends up holding the signed remainder, C the quotient
    assign res_o.quotient  = opc_r[W-1:0];
    assign res_o.remainder = opa_r[W-1:0];

    // the FSM must never select two sources into a loading register
    a_opb_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        ctrl_i.opb_ld |-> $onehot(ctrl_i.opb_sel))
        else $error("opb_sel not one-hot while B loads");

    a_opc_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
        ctrl_i.opc_ld |-> $onehot(ctrl_i.opc_sel))
        else $error("opc_sel not one-hot while C loads");

endmodule

`default_nettype wire

//--- rtl/idiv_iterative.sv
// ==========================================================
// iterative integer divider, top level
//   FSM controller plus operand datapath
// ==========================================================

`include "idiv_consts.svh"

`default_nettype none

module idiv_iterative import idiv_pkg::*; (
    input  logic      clk_i,
    input  logic      reset_i,

    // request side, valid/ready
    input  logic      req_v_i,
    input  idiv_req_t req_i,
    output logic      req_ready_o,

    // result side, valid/yumi
    output logic      res_v_o,
    output idiv_res_t res_o,
    input  logic      res_yumi_i
);

    idiv_ctrl_t   ctrl;
    idiv_status_t status;

    idiv_controller u_ctrl (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .v_i      (req_v_i),
        .ready_o  (req_ready_o),
        .status_i (status),
        .ctrl_o   (ctrl),
        .v_o      (res_v_o),
        .yumi_i   (res_yumi_i)
    );

    idiv_datapath u_dp (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .req_i    (req_i),
        .ctrl_i   (ctrl),
        .status_o (status),
        .res_o    (res_o)
    );

endmodule

`default_nettype wire

//--- verification/idiv_tb.sv
// ==========================================================
// testbench for the iterative divider
//   clock, reset, directed and random requests,
//   reference model, result checker, back-pressure consumer
// ==========================================================

`include "idiv_consts.svh"

`default_nettype none

module idiv_tb import idiv_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int W          = `IDIV_WIDTH;
    localparam int WAIT_LIMIT = 4 * W + 200;

    logic        clk_i      = 1'b0;
    logic        reset_i    = 1'b1;
    logic        req_v_i    = 1'b0;
    idiv_req_t   req_i      = '0;
    logic        res_yumi_i = 1'b0;
    logic        req_ready_o;
    logic        res_v_o;
    idiv_res_t   res_o;

    idiv_req_t   pending_q[$];
    idiv_res_t   held_res;
    logic        hold_pending = 1'b0;
    logic [31:0] rng_state    = 32'he602;
    logic [31:0] stall_rng    = ~32'he602;
    int          stall_max    = 0;
    int          stall_left   = -1;
    int          check_pass   = 0;
    int          check_fail   = 0;
    int          test_pass0   = 0;
    int          test_fail0   = 0;
    string       test_name;

    idiv_iterative DUT (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .req_v_i     (req_v_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .res_v_o     (res_v_o),
        .res_o       (res_o),
        .res_yumi_i  (res_yumi_i)
    );

    always #5 clk_i = ~clk_i;

    // ==========================================================
    // reference model and helpers
    // ==========================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [W-1:0] to_word(input int x);
        return W'(x);
    endfunction

    // truncating division, remainder takes the dividend sign
    function automatic idiv_res_t ref_divide(input logic [W-1:0] dvd, input logic [W-1:0] dvs,
                                             input logic sgn);
        idiv_res_t    res;
        logic         neg_n;
        logic         neg_d;
        logic [W-1:0] mag_n;
        logic [W-1:0] mag_d;
        if (dvs == '0) begin
            res.quotient  = '1;
            res.remainder = dvd;
            return res;
        end
        neg_n = sgn & dvd[W-1];
        neg_d = sgn & dvs[W-1];
        mag_n = neg_n ? -dvd : dvd;
        mag_d = neg_d ? -dvs : dvs;
        res.quotient  = (neg_n ^ neg_d) ? -(mag_n / mag_d) : mag_n / mag_d;
        res.remainder = neg_n ? -(mag_n % mag_d) : mag_n % mag_d;
        return res;
    endfunction

    task automatic draw_word(output logic [W-1:0] v);
        logic [63:0] wide;
        rng_state   = xorshift32(rng_state);
        wide[31:0]  = rng_state;
        rng_state   = xorshift32(rng_state);
        wide[63:32] = rng_state;
        v = wide[W-1:0];
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, WAIT_LIMIT);
        $display("checks passed: %0d, checks failed: %0d", check_pass, check_fail + 1);
        $display("FAIL: see errors above");
        $finish;
    endtask

    task automatic send_request(input logic [W-1:0] dvd, input logic [W-1:0] dvs,
                                input logic sgn);
        int waited;
        waited = 0;
        @(negedge clk_i);
        while (!req_ready_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("req_ready_o");
            end
            @(negedge clk_i);
        end
        req_i.dividend   = dvd;
        req_i.divisor    = dvs;
        req_i.signed_div = sgn;
        req_v_i          = 1'b1;
        @(negedge clk_i);
        req_v_i = 1'b0;
    endtask

    task automatic send_random();
        logic [W-1:0] dvd;
        logic [W-1:0] dvs;
        draw_word(dvd);
        draw_word(dvs);
        rng_state = xorshift32(rng_state);
        // vary the divisor length so quotients span many sizes
        dvs = dvs >> (int'(rng_state[7:0]) % W);
        send_request(dvd, dvs, rng_state[8]);
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (pending_q.size() != 0 || res_v_o) begin
            waited++;
            if (waited > WAIT_LIMIT) begin
                report_timeout("res_v_o");
            end
            @(negedge clk_i);
        end
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        test_pass0 = check_pass;
        test_fail0 = check_fail;
    endtask

    task automatic end_test();
        $display("test %s: %0d checks, %0d errors", test_name,
                 check_pass + check_fail - test_pass0 - test_fail0, check_fail - test_fail0);
    endtask

    // ==========================================================
    // consumer and result checker
    // ==========================================================

    // yumi after a random stall of up to stall_max cycles
    always @(negedge clk_i) begin
        if (reset_i || !res_v_o || res_yumi_i) begin
            res_yumi_i = 1'b0;
            stall_left = -1;
        end else begin
            if (stall_left < 0) begin
                stall_rng  = xorshift32(stall_rng);
                stall_left = int'(stall_rng % 32'(stall_max + 1));
            end
            if (stall_left == 0) begin
                res_yumi_i = 1'b1;
            end else begin
                stall_left--;
            end
        end
    end

    always @(posedge clk_i) begin
        idiv_req_t req;
        idiv_res_t exp;
        if (!reset_i) begin
            if (req_v_i && req_ready_o) begin
                pending_q.push_back(req_i);
            end
            if (res_v_o && req_ready_o) begin
                $display("req_ready_o and res_v_o are high in the same cycle");
                check_fail++;
            end
            // a result waiting for yumi must not move
            if (hold_pending) begin
                if (!res_v_o) begin
                    $display("res_v_o dropped before res_yumi_i");
                    check_fail++;
                end else if (res_o !== held_res) begin
                    $display("Fail res_o: held %h, changed to %h", held_res, res_o);
                    check_fail++;
                end else begin
                    check_pass++;
                end
            end
            hold_pending = res_v_o && !res_yumi_i;
            held_res     = res_o;
            if (res_v_o && res_yumi_i) begin
                if (pending_q.size() == 0) begin
                    $display("result delivered with no request outstanding");
                    check_fail++;
                end else begin
                    req = pending_q.pop_front();
                    exp = ref_divide(req.dividend, req.divisor, req.signed_div);
                    if (res_o.quotient !== exp.quotient) begin
                        $display("Fail res_o.quotient: %h / %h signed %0d, expected %h actual %h",
                                 req.dividend, req.divisor, req.signed_div,
                                 exp.quotient, res_o.quotient);
                        check_fail++;
                    end else begin
                        check_pass++;
                    end
                    if (res_o.remainder !== exp.remainder) begin
                        $display("Fail res_o.remainder: %h / %h signed %0d, expected %h actual %h",
                                 req.dividend, req.divisor, req.signed_div,
                                 exp.remainder, res_o.remainder);
                        check_fail++;
                    end else begin
                        check_pass++;
                    end
                end
            end
        end
    end

    // ==========================================================
    // test sequence
    // ==========================================================

    initial begin
        logic [W-1:0] a;
        logic [W-1:0] b;
        logic [W-1:0] min_neg;
        min_neg = {1'b1, {(W - 1){1'b0}}};
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        reset_i = 1'b0;

        start_test("1 reset state and unsigned division");
        if (req_ready_o !== 1'b1) begin
            $display("Fail req_ready_o: expected 1 actual %h", req_ready_o);
            check_fail++;
        end else begin
            check_pass++;
        end
        if (res_v_o !== 1'b0) begin
            $display("Fail res_v_o: expected 0 actual %h", res_v_o);
            check_fail++;
        end else begin
            check_pass++;
        end
        send_request(to_word(100), to_word(7), 1'b0);
        send_request(to_word(5), to_word(9), 1'b0);
        send_request('1, to_word(16), 1'b0);
        send_request('0, to_word(3), 1'b0);
        wait_drained();
        end_test();

        start_test("2 signed operand signs");
        for (int i = 0; i < 4; i++) begin
            a = i[0] ? to_word(-100) : to_word(100);
            b = i[1] ? to_word(-7) : to_word(7);
            send_request(a, b, 1'b1);
            send_request(b, a, 1'b1);
        end
        wait_drained();
        end_test();

        start_test("3 division by zero");
        send_request(to_word(1234), '0, 1'b0);
        send_request('1, '0, 1'b0);
        send_request(to_word(-1234), '0, 1'b1);
        send_request(to_word(1234), '0, 1'b1);
        send_request(min_neg, '0, 1'b1);
        wait_drained();
        end_test();

        start_test("4 overflow and unit divisors");
        send_request(min_neg, '1, 1'b1);
        send_request(min_neg, to_word(1), 1'b1);
        send_request(min_neg, to_word(1), 1'b0);
        send_request(to_word(12345), '1, 1'b0);
        send_request(to_word(12345), '1, 1'b1);
        send_request(to_word(-12345), to_word(1), 1'b1);
        send_request('1, '1, 1'b0);
        send_request(min_neg, min_neg, 1'b1);
        wait_drained();
        end_test();

        start_test("5 back-pressure");
        stall_max = 12;
        repeat (20) send_random();
        wait_drained();
        stall_max = 0;
        end_test();

        start_test("6 random back-to-back");
        repeat (400) send_random();
        wait_drained();
        end_test();

        $display("checks passed: %0d, checks failed: %0d", check_pass, check_fail);
        if (check_fail == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- idiv_iterative.f
+incdir+rtl
rtl/idiv_pkg.sv
rtl/idiv_controller.sv
rtl/idiv_datapath.sv
rtl/idiv_iterative.sv
verification/idiv_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= idiv_tb
FILELIST  ?= idiv_iterative.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := PASS: all tests

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, look for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
